//--- common/ac97_link_pkg.sv
package ac97_link_pkg;

	////////////////////
	// Frame geometry
	////////////////////

	localparam int frame_bits = 256; // Bit clocks per frame
	localparam int tag_bits = 16;    // Slot 0
	localparam int slot_bits = 20;   // Slots 1..12

	typedef logic [slot_bits-1:0] sample_t;
	typedef logic [slot_bits-1:0] slot_t;
	typedef logic [$clog2(frame_bits)-1:0] bit_index_t;

	////////////////////
	// Slot positions
	////////////////////

	// LSB of each slot inside the frame vector, MSB of frame is bit 255
	localparam int slot1_lsb = frame_bits - tag_bits - slot_bits;
	localparam int slot2_lsb = slot1_lsb - slot_bits;
	localparam int slot3_lsb = slot2_lsb - slot_bits;
	localparam int slot4_lsb = slot3_lsb - slot_bits;

	////////////////////
	// Tag bits
	////////////////////

	// Outgoing tag
	localparam int tag_frame_valid = 15;
	localparam int tag_slot1 = 14;        // Command address
	localparam int tag_slot2 = 13;        // Command data
	localparam int tag_slot3 = 12;        // Left PCM
	localparam int tag_slot4 = 11;        // Right PCM

	// Incoming tag
	localparam int tag_codec_ready = 15;

endpackage

//--- common/ac97_codec_pkg.sv
package ac97_codec_pkg;

	typedef logic [7:0] reg_addr_t;   // Bit 7 read flag, 6..0 index
	typedef logic [15:0] reg_data_t;

	////////////////////
	// Register map
	////////////////////

	localparam reg_addr_t reg_master_vol = 8'h02;
	localparam reg_addr_t reg_line_in = 8'h10;
	localparam reg_addr_t reg_rec_sel = 8'h1A;
	localparam reg_addr_t reg_rec_gain = 8'h1C;
	localparam reg_addr_t reg_powerdown = 8'h26; // Power-down ctrl/status

	localparam reg_addr_t cmd_read = 8'h80;      // Read request flag

	// Bring-up values
	localparam reg_data_t rec_sel_value = 16'h0404; // Line in, both channels
	localparam reg_data_t zero_gain = 16'h0000;     // 0 dB, unmuted

	////////////////////
	// Controller states
	////////////////////

	typedef enum logic [2:0] {
		st_wait_ready,
		st_master,
		st_line_in,
		st_rec_sel,
		st_rec_gain,
		st_stream
	} init_state_t;

endpackage

//--- common/ac97_ifs.sv
`timescale 1ns/1ps

// Bit and frame strobes from the link timing block
interface ac97_frame_if import ac97_link_pkg::*; ();
	logic bit_rise;
	logic bit_fall;
	bit_index_t bit_index;
	logic frame_start;
	logic frame_done;

	modport timing (
		output bit_rise, bit_fall, bit_index, frame_start, frame_done
	);
	modport sink (
		input bit_rise, bit_fall, bit_index, frame_start, frame_done
	);
endinterface

// Controller levels toward the serializer
interface ac97_out_if import ac97_link_pkg::*, ac97_codec_pkg::*; ();
	logic cmd_vd;
	reg_addr_t cmd_addr;
	reg_data_t cmd_data;
	logic left_vd;
	logic right_vd;
	sample_t leftdac;
	sample_t rightdac;

	modport ctrl (
		output cmd_vd, cmd_addr, cmd_data, left_vd, right_vd, leftdac, rightdac
	);
	modport link (
		input cmd_vd, cmd_addr, cmd_data, left_vd, right_vd, leftdac, rightdac
	);
endinterface

// Received frame contents toward the controller
interface ac97_in_if import ac97_link_pkg::*; ();
	logic codec_ready;
	slot_t reg_status;
	slot_t status_data;
	sample_t leftadc;
	sample_t rightadc;

	modport link (
		output codec_ready, reg_status, status_data, leftadc, rightadc
	);
	modport ctrl (
		input codec_ready, reg_status, status_data, leftadc, rightadc
	);
endinterface

//--- ac97_link/ac97_link_timing.sv
`timescale 1ns/1ps

module ac97_link_timing import ac97_link_pkg::*; (
	input logic CCLK,
	input logic rst,
	input logic bit_clk,
	output logic sync,
	ac97_frame_if.timing frm
);

	logic bclk_meta;
	logic bclk_sync;
	logic bclk_last;   // Edge detect reference
	logic last_bit;

	////////////////////
	// Bit clock edges
	////////////////////

	always_ff @(posedge CCLK) begin
		if (!rst) begin
			bclk_meta <= 1'b0;
			bclk_sync <= 1'b0;
			bclk_last <= 1'b0;
			frm.bit_rise <= 1'b0;
			frm.bit_fall <= 1'b0;
		end else begin
			bclk_meta <= bit_clk;
			bclk_sync <= bclk_meta;
			bclk_last <= bclk_sync;
			frm.bit_rise <= bclk_sync & ~bclk_last; // 3 CCLK after the pin edge
			frm.bit_fall <= ~bclk_sync & bclk_last;
		end
	end

	////////////////////
	// Bit counter, sync
	////////////////////

	assign last_bit = (frm.bit_index == bit_index_t'(frame_bits - 1));

	always_ff @(posedge CCLK) begin
		if (!rst) begin
			frm.bit_index <= bit_index_t'(frame_bits - 1); // First rise wraps to bit 0
			sync <= 1'b0;
		end else if (frm.bit_rise) begin
			frm.bit_index <= frm.bit_index + 1'b1;
			if (last_bit) begin
				sync <= 1'b1;
			end else if (frm.bit_index == bit_index_t'(tag_bits - 1)) begin
				sync <= 1'b0; // Tag phase over
			end
		end
	end

	assign frm.frame_start = frm.bit_rise & last_bit;
	assign frm.frame_done = frm.bit_fall & last_bit;

endmodule

//--- ac97_link/ac97_frame_tx.sv
`timescale 1ns/1ps

module ac97_frame_tx import ac97_link_pkg::*, ac97_codec_pkg::*; (
	input logic CCLK,
	input logic rst,
	ac97_frame_if.sink frm,
	ac97_out_if.link out,
	output logic sdata_out
);

	logic [tag_bits-1:0] tag;
	logic [frame_bits-1:0] frame_word;
	logic [frame_bits-1:0] frame_sr;
	logic cmd_write;

	// A read carries no data slot
	assign cmd_write = out.cmd_vd && ((out.cmd_addr & cmd_read) == '0);

	////////////////////
	// Frame assembly
	////////////////////

	always_comb begin
		tag = '0;
		tag[tag_frame_valid] = out.cmd_vd | out.left_vd | out.right_vd;
		tag[tag_slot1] = out.cmd_vd;
		tag[tag_slot2] = cmd_write;
		tag[tag_slot3] = out.left_vd;
		tag[tag_slot4] = out.right_vd;

		frame_word = '0;
		frame_word[frame_bits-1 -: tag_bits] = tag;
		if (tag[tag_slot1]) begin
			// Address in 19..12
			frame_word[slot1_lsb +: slot_bits] = {out.cmd_addr, 12'h000};
		end
		if (tag[tag_slot2]) begin
			frame_word[slot2_lsb +: slot_bits] = {out.cmd_data, 4'h0}; // Data in 19..4
		end
		if (tag[tag_slot3]) begin
			frame_word[slot3_lsb +: slot_bits] = out.leftdac;
		end
		if (tag[tag_slot4]) begin
			frame_word[slot4_lsb +: slot_bits] = out.rightdac;
		end
	end

	////////////////////
	// Serializer
	////////////////////

	// Remaining bits of the frame
	always_ff @(posedge CCLK) begin
		if (frm.frame_start) begin
			frame_sr <= {frame_word[frame_bits-2:0], 1'b0};
		end else if (frm.bit_rise) begin
			frame_sr <= {frame_sr[frame_bits-2:0], 1'b0};
		end
	end

	always_ff @(posedge CCLK) begin
		if (!rst) begin
			sdata_out <= 1'b0;
		end else if (frm.frame_start) begin
			sdata_out <= frame_word[frame_bits-1]; // Tag MSB with bit 0
		end else if (frm.bit_rise) begin
			sdata_out <= frame_sr[frame_bits-1];
		end
	end

endmodule

//--- ac97_link/ac97_frame_rx.sv
`timescale 1ns/1ps

module ac97_frame_rx import ac97_link_pkg::*; (
	input logic CCLK,
	input logic rst,
	ac97_frame_if.sink frm,
	input logic sdata_in,
	ac97_in_if.link inp
);

	logic [frame_bits-1:0] rx_sr;
	logic [frame_bits-1:0] rx_next;  // Frame including the bit taken now

	assign rx_next = {rx_sr[frame_bits-2:0], sdata_in};

	////////////////////
	// Deserializer
	////////////////////

	// Codec drives on rising bit_clk, sample mid bit
	always_ff @(posedge CCLK) begin
		if (frm.bit_fall) begin
			rx_sr <= rx_next;
		end
	end

	////////////////////
	// Frame end latch
	////////////////////

	always_ff @(posedge CCLK) begin
		if (!rst) begin
			inp.codec_ready <= 1'b0;
			inp.reg_status <= '0;
			inp.status_data <= '0;
		end else if (frm.frame_done) begin
			inp.codec_ready <= rx_next[frame_bits - tag_bits + tag_codec_ready];
			inp.reg_status <= rx_next[slot1_lsb +: slot_bits];  // Echoed address
			inp.status_data <= rx_next[slot2_lsb +: slot_bits]; // Register contents
		end
	end

	// ADC samples
	always_ff @(posedge CCLK) begin
		if (frm.frame_done) begin
			inp.leftadc <= rx_next[slot3_lsb +: slot_bits];
			inp.rightadc <= rx_next[slot4_lsb +: slot_bits];
		end
	end

endmodule

//--- src/ac97_init_ctrl.sv
`timescale 1ns/1ps

module ac97_init_ctrl import ac97_codec_pkg::*; (
	input logic CCLK,
	input logic rst,
	ac97_frame_if.sink frm,
	ac97_in_if.ctrl inp,
	ac97_out_if.ctrl out,
	output logic init_led
);

	init_state_t state;
	logic done_q;  // Frame done delayed until rx levels settle
	logic set;     // Command has been loaded by tx

	always_ff @(posedge CCLK) begin
		if (!rst) begin
			state <= st_wait_ready;
			done_q <= 1'b0;
			set <= 1'b0;
			init_led <= 1'b0;
			out.cmd_vd <= 1'b0;
			out.cmd_addr <= '0;
			out.cmd_data <= '0;
			out.left_vd <= 1'b0;
			out.right_vd <= 1'b0;
			out.leftdac <= '0;
			out.rightdac <= '0;
		end else begin
			done_q <= frm.frame_done;
			if (frm.frame_start && out.cmd_vd)
				set <= 1'b1;

			if (done_q) begin
				case (state)
					st_wait_ready: begin
						// Poll power-down status until all sections are up
						if (inp.codec_ready) begin
							init_led <= 1'b1;
							out.cmd_vd <= 1'b1;
							out.cmd_addr <= cmd_read | reg_powerdown;
							if (out.cmd_vd && inp.reg_status[18:12] == reg_powerdown[6:0]
									&& inp.status_data[7:4] == 4'hF) begin
								state <= st_master;
								init_led <= 1'b0;
								out.cmd_addr <= reg_master_vol;
								out.cmd_data <= zero_gain;
								set <= 1'b0;
							end
						end
					end
					st_master: if (set) begin
						state <= st_line_in;
						out.cmd_addr <= reg_line_in;
						out.cmd_data <= zero_gain;
						set <= 1'b0;
					end
					st_line_in: if (set) begin
						state <= st_rec_sel;
						out.cmd_addr <= reg_rec_sel;
						out.cmd_data <= rec_sel_value;
						set <= 1'b0;
					end
					st_rec_sel: if (set) begin
						state <= st_rec_gain;
						out.cmd_addr <= reg_rec_gain;
						out.cmd_data <= zero_gain;
						set <= 1'b0;
					end
					st_rec_gain: if (set) begin
						// Loopback starts after the last write
						state <= st_stream;
						out.cmd_vd <= 1'b0;
						init_led <= 1'b0;
						out.left_vd <= 1'b1;
						out.right_vd <= 1'b1;
						out.leftdac <= inp.leftadc;
						out.rightdac <= inp.rightadc;
						set <= 1'b0;
					end
					st_stream: begin
						out.leftdac <= inp.leftadc;   // Leaves in next frame
						out.rightdac <= inp.rightadc;
					end
					default: state <= st_wait_ready;
				endcase
			end
		end
	end

endmodule

//--- src/ac97_loopback.sv
`timescale 1ns/1ps

module ac97_loopback (
	input logic CCLK,
	input logic rst,
	input logic bit_clk,
	input logic sdata_in,
	output logic sync,
	output logic sdata_out,
	output logic init_led
);

	ac97_frame_if frm_if ();
	ac97_out_if out_if ();
	ac97_in_if in_if ();

	////////////////////
	// Link
	////////////////////

	ac97_link_timing u_timing (
		.CCLK(CCLK),
		.rst(rst),
		.bit_clk(bit_clk),
		.sync(sync),
		.frm(frm_if.timing)
	);

	ac97_frame_tx u_tx (
		.CCLK(CCLK),
		.rst(rst),
		.frm(frm_if.sink),
		.out(out_if.link),
		.sdata_out(sdata_out)
	);

	ac97_frame_rx u_rx (
		.CCLK(CCLK),
		.rst(rst),
		.frm(frm_if.sink),
		.sdata_in(sdata_in),
		.inp(in_if.link)
	);

	////////////////////
	// Control
	////////////////////

	ac97_init_ctrl u_ctrl (
		.CCLK(CCLK),
		.rst(rst),
		.frm(frm_if.sink),
		.inp(in_if.ctrl),
		.out(out_if.ctrl),
		.init_led(init_led)
	);

endmodule

//--- test/tb_ac97_loopback.sv
`timescale 1ns/1ps

module tb_ac97_loopback;

	// About 30 frames of 2560 CCLK where 18 are needed
	localparam int timeout_cycles = 80000;
	localparam int stream_target = 8;

	logic CCLK;
	logic rst;
	logic bit_clk;
	logic sdata_in;
	logic sync;
	logic sdata_out;
	logic init_led;

	// Codec model
	bit clk_started;
	logic [7:0] codec_bit;
	int codec_frame;
	logic codec_sync_q;
	logic [255:0] codec_word;
	logic [15:0] tag_in;
	logic [19:0] slot1_in;
	logic [19:0] slot2_in;
	logic [19:0] left_in;
	logic [19:0] right_in;
	logic [255:0] sent_frames[$];
	logic [19:0] adc_left[$];
	logic [19:0] adc_right[$];

	// Frame capture
	logic [255:0] cap_frame;
	logic [255:0] exp_frame;
	logic [7:0] cap_bit;
	logic led_first;
	int out_frame;
	int stream_checked;
	int cycle_count;

	// Reference model state
	logic m_reading;   // Power-down status poll active
	int m_write;       // Write list index or -1 when idle
	logic m_stream;
	logic m_led;
	logic [19:0] m_left;
	logic [19:0] m_right;
	logic exp_led;

	ac97_loopback dut_i (
		.CCLK(CCLK),
		.rst(rst),
		.bit_clk(bit_clk),
		.sdata_in(sdata_in),
		.sync(sync),
		.sdata_out(sdata_out),
		.init_led(init_led)
	);

	always #4 CCLK = ~CCLK;

	////////////////////
	// Checks
	////////////////////

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			$display("Error: %s = %0h, expected %0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_outputs_low();
		check_value("sync", 256'(sync), 256'h0);
		check_value("sdata_out", 256'(sdata_out), 256'h0);
		check_value("init_led", 256'(init_led), 256'h0);
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [23:0] write_cmd(int idx);
		case (idx)
			0: return {8'h02, 16'h0000};       // Master volume
			1: return {8'h10, 16'h0000};       // Line-in gain
			2: return {8'h1A, 16'h0404};       // Record select to line in
			default: return {8'h1C, 16'h0000}; // Record gain
		endcase
	endfunction

	// Controller reaction to incoming frame n
	function automatic void advance_model(int n);
		logic [255:0] rx;
		rx = sent_frames[n];
		if (m_stream) begin
			m_left = adc_left[n];
			m_right = adc_right[n];
		end else if (m_write >= 0) begin
			if (m_write == 3) begin
				m_write = -1;
				m_stream = 1'b1;
				m_led = 1'b0;
				m_left = adc_left[n];
				m_right = adc_right[n];
			end else begin
				m_write = m_write + 1;
			end
		end else if (rx[255]) begin
			// Slot 1 index at frame bits 238..232 and slot 2 bits 7..4 at 207..204
			if (m_reading && rx[238:232] == 7'h26 && rx[207:204] == 4'hF) begin
				m_reading = 1'b0;
				m_write = 0;
				m_led = 1'b0;
			end else begin
				m_reading = 1'b1;
				m_led = 1'b1;
			end
		end
	endfunction

	function automatic logic [255:0] expected_frame(int n);
		logic [15:0] tag;
		logic [19:0] s1;
		logic [19:0] s2;
		logic [19:0] s3;
		logic [19:0] s4;
		logic [23:0] cmd;
		if (n > 0)
			advance_model(n - 1);
		tag = '0;
		s1 = '0;
		s2 = '0;
		s3 = '0;
		s4 = '0;
		if (m_reading) begin
			tag[15:14] = 2'b11;
			s1 = {8'hA6, 12'h000}; // Read of 26 without a data slot
		end else if (m_write >= 0) begin
			cmd = write_cmd(m_write);
			tag[15:13] = 3'b111;
			s1 = {cmd[23:16], 12'h000};
			s2 = {cmd[15:0], 4'h0};
		end else if (m_stream) begin
			tag[15] = 1'b1;
			tag[12:11] = 2'b11;
			s3 = m_left;
			s4 = m_right;
		end
		exp_led = m_led;
		return {tag, s1, s2, s3, s4, 160'h0};
	endfunction

	////////////////////
	// Codec model
	////////////////////

	always begin
		#40;
		bit_clk = 1'b1;
		clk_started = 1'b1;
		if (codec_bit == 8'd255) begin
			codec_frame = codec_frame + 1;
			left_in = 20'($urandom);
			right_in = 20'($urandom);
			tag_in = 16'h1800;          // ADC slots valid
			slot1_in = '0;
			slot2_in = '0;
			if (codec_frame >= 3)
				tag_in[15] = 1'b1;      // Codec ready
			if (codec_frame >= 5) begin
				tag_in[14:13] = 2'b11;
				slot1_in = {8'h26, 12'h000};
				slot2_in = 20'h000F0;   // Power-down nibble F
			end
			codec_word = {tag_in, slot1_in, slot2_in, left_in, right_in, 160'h0};
			sent_frames.push_back(codec_word);
			adc_left.push_back(left_in);
			adc_right.push_back(right_in);
		end
		codec_bit = codec_bit + 8'd1;
		sdata_in = codec_word[8'd255 - codec_bit];
		#40;
		bit_clk = 1'b0;
		// Realign on a new sync pulse
		if (sync && !codec_sync_q)
			codec_bit = 8'd0;
		codec_sync_q = sync;
	end

	////////////////////
	// Frame capture
	////////////////////

	always @(negedge bit_clk) begin
		if (clk_started) begin
			cap_frame = {cap_frame[254:0], sdata_out};
			check_value("sync", 256'(sync), 256'(cap_bit < 8'd16)); // Tag phase only
			if (cap_bit == 8'd0)
				led_first = init_led;
			else
				check_value("init_led", 256'(init_led), 256'(led_first));
			if (cap_bit == 8'd255) begin
				exp_frame = expected_frame(out_frame);
				check_value("sdata_out frame", cap_frame, exp_frame);
				check_value("init_led", 256'(led_first), 256'(exp_led));
				if (m_stream)
					stream_checked = stream_checked + 1;
				out_frame = out_frame + 1;
			end
			cap_bit = cap_bit + 8'd1;
		end
	end

	always @(posedge CCLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("TEST FAILED");
			$fatal(1, "Timeout after %0d CCLK cycles before streaming was checked", cycle_count);
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		void'($urandom(63));
		CCLK = 1'b0;
		rst = 1'b0;
		bit_clk = 1'b0;
		sdata_in = 1'b0;
		codec_bit = 8'd255;  // First rise begins frame 0
		codec_frame = -1;
		codec_sync_q = 1'b0;
		codec_word = '0;
		cap_frame = '0;
		cap_bit = 8'd0;
		led_first = 1'b0;
		out_frame = 0;
		stream_checked = 0;
		cycle_count = 0;
		m_reading = 1'b0;
		m_write = -1;
		m_stream = 1'b0;
		m_led = 1'b0;
		m_left = '0;
		m_right = '0;
		exp_led = 1'b0;

		@(negedge CCLK);
		check_outputs_low();
		@(negedge CCLK);
		check_outputs_low();
		rst = 1'b1;

		// Quiet until the first bit clock edge
		while (!clk_started) begin
			@(negedge CCLK);
			check_outputs_low();
		end

		wait (stream_checked >= stream_target);
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- ac97_loopback.f
common/ac97_link_pkg.sv
common/ac97_codec_pkg.sv
common/ac97_ifs.sv
ac97_link/ac97_link_timing.sv
ac97_link/ac97_frame_tx.sv
ac97_link/ac97_frame_rx.sv
src/ac97_init_ctrl.sv
src/ac97_loopback.sv
test/tb_ac97_loopback.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AC'97 loopback testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	--timescale 1ns/1ps \
	--top-module tb_ac97_loopback \
	--Mdir obj_dir \
	-o sim_tb \
	-f ac97_loopback.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished without errors"
exit 0
